// ==== src/bbc_mem_pkg.sv ====
package bbc_mem_pkg;

	// sdram word address width
	localparam int sdram_aw = 25;

	// counter widths for the reset glue
	localparam int hold_cnt_w = 12;
	localparam int boot_cnt_w = 25;

	// reset held this long after the rom mapping option flips
	localparam logic [hold_cnt_w-1:0] remap_hold_cycles = 12'd4095;
	// one second of shift at 32 MHz
	localparam logic [boot_cnt_w-1:0] autoboot_cycles = 25'd32_000_000;

	// rom bank numbers for the high and low mappings
	localparam logic [3:0] romsel_basic_high = 4'he;
	localparam logic [3:0] romsel_basic_low  = 4'h0;
	localparam logic [3:0] romsel_mmfs_high  = 4'hc;
	localparam logic [3:0] romsel_mmfs_low   = 4'h2;
	localparam logic [3:0] romsel_swram_a    = 4'ha; // extra sideways ram bank

	// banks 4..7 are sideways ram
	localparam logic [1:0] sideways_bank_prefix = 2'b01;

	// upper bits of a paged sdram address above the 64k of main ram
	localparam logic [6:0] paged_adr_prefix = 7'b0000001;

	typedef enum logic [1:0] {
		region_ram    = 2'd0, // 0000-7fff
		region_mos    = 2'd1, // c000-ffff
		region_swram  = 2'd2, // banks 4..7 at 8000-bfff
		region_paged  = 2'd3  // other banks at 8000-bfff
	} mem_region_e;

	typedef enum logic [1:0] {
		st_hold = 2'd0, // core held in reset
		st_boot = 2'd1, // running with shift pressed
		st_run  = 2'd2
	} reset_state_e;

endpackage

// ==== src/cpu_bus_if.sv ====
`timescale 1ns/1ps

// cpu side of the memory bus plus decoded region and read byte
interface cpu_bus_if;
	logic [15:0] adr;
	logic [3:0]  romsel;
	logic        we;
	logic [7:0]  wdata;
	bbc_mem_pkg::mem_region_e region;
	logic [7:0]  rdata;

	// address mapper decodes the region
	modport mapper (
		input  adr, romsel, we, wdata,
		output region
	);

	// read side picks the data byte
	modport reader (
		input  adr, romsel, region,
		output rdata
	);
endinterface

// ==== src/loader_if.sv ====
`timescale 1ns/1ps

// file loader write port that takes over the sdram port while active
interface loader_if;
	logic                             active;
	logic                             we;   // level sampled by the sdram controller
	logic [bbc_mem_pkg::sdram_aw-1:0] addr;
	logic [7:0]                       data;

	modport mux (
		input active, we, addr, data
	);
endinterface

// ==== src/reset_ctrl.sv ====
`timescale 1ns/1ps

module reset_ctrl (
	input  logic clk_32m,
	input  logic reset,
	input  logic sdram_ready,
	input  logic menu_reset,
	input  logic core_button,
	input  logic loader_active,
	input  logic rom_map_low,
	input  logic auto_boot,
	input  logic mem_sync,
	output logic core_reset,
	output logic autoboot_shift
);

	logic                               last_rom_map;
	logic [bbc_mem_pkg::hold_cnt_w-1:0] hold_cnt;
	logic                               remap_hold;
	logic                               reset_req;
	logic [bbc_mem_pkg::boot_cnt_w-1:0] boot_cnt;
	bbc_mem_pkg::reset_state_e          state;

	// hold the core in reset for a while after the rom mapping flips
	always_ff @(posedge clk_32m) begin
		if (reset) begin
			last_rom_map <= rom_map_low; // no spurious hold out of reset
			hold_cnt     <= '0;
		end else begin
			last_rom_map <= rom_map_low;
			if (last_rom_map != rom_map_low)
				hold_cnt <= bbc_mem_pkg::remap_hold_cycles;
			else if (hold_cnt != '0)
				hold_cnt <= hold_cnt - 1'b1;
		end
	end

	assign remap_hold = (hold_cnt != '0);

	// any of these keeps the core in reset
	assign reset_req = !sdram_ready || menu_reset || core_button ||
		loader_active || remap_hold;

	// only change the core reset in step with the memory cycle
	always_ff @(posedge clk_32m) begin
		if (reset)
			core_reset <= 1'b1;
		else if (mem_sync)
			core_reset <= reset_req;
	end

	// auto-boot window holds shift for a fixed time after release
	always_ff @(posedge clk_32m) begin
		if (reset) begin
			state    <= bbc_mem_pkg::st_hold;
			boot_cnt <= '0;
		end else if (core_reset) begin
			state    <= bbc_mem_pkg::st_hold; // restart on every reset
			boot_cnt <= '0;
		end else begin
			case (state)
				bbc_mem_pkg::st_hold: begin
					state    <= bbc_mem_pkg::st_boot;
					boot_cnt <= '0;
				end
				bbc_mem_pkg::st_boot: begin
					if (boot_cnt == bbc_mem_pkg::autoboot_cycles - 1'b1)
						state <= bbc_mem_pkg::st_run;
					else
						boot_cnt <= boot_cnt + 1'b1;
				end
				default: state <= bbc_mem_pkg::st_run;
			endcase
		end
	end

	assign autoboot_shift = auto_boot && (state == bbc_mem_pkg::st_boot);

endmodule

// ==== src/sdram_port_mux.sv ====
`timescale 1ns/1ps

module sdram_port_mux (
	cpu_bus_if.mapper                        cpu,
	loader_if.mux                            ldr,
	output logic [bbc_mem_pkg::sdram_aw-1:0] sdram_adr,
	output logic                             sdram_we,
	output logic [7:0]                       sdram_wdata
);

	logic cpu_wr_ok;

	// region decode from the top address bits and the rom select
	always_comb begin
		if (!cpu.adr[15])
			cpu.region = bbc_mem_pkg::region_ram;
		else if (cpu.adr[14])
			cpu.region = bbc_mem_pkg::region_mos;
		else if (cpu.romsel[3:2] == bbc_mem_pkg::sideways_bank_prefix)
			cpu.region = bbc_mem_pkg::region_swram;
		else
			cpu.region = bbc_mem_pkg::region_paged;
	end

	// rom regions are read only
	assign cpu_wr_ok = (cpu.region == bbc_mem_pkg::region_ram) ||
		(cpu.region == bbc_mem_pkg::region_swram);

	always_comb begin
		if (ldr.active) begin
			sdram_adr   = ldr.addr; // loader owns the port
			sdram_we    = ldr.we;
			sdram_wdata = ldr.data;
		end else begin
			if (cpu.region == bbc_mem_pkg::region_ram)
				sdram_adr = {{(bbc_mem_pkg::sdram_aw-16){1'b0}}, cpu.adr};
			else
				sdram_adr = {bbc_mem_pkg::paged_adr_prefix, cpu.romsel, cpu.adr[13:0]};
			sdram_we    = cpu.we && cpu_wr_ok;
			sdram_wdata = cpu.wdata;
		end
	end

endmodule

// ==== src/cpu_read_mux.sv ====
`timescale 1ns/1ps

module cpu_read_mux (
	cpu_bus_if.reader  cpu,
	input  logic       rom_map_low,
	input  logic [7:0] ram_rdata,
	input  logic [7:0] os_rdata,
	input  logic [7:0] basic_rdata,
	input  logic [7:0] mmfs_rdata
);

	logic [3:0] basic_bank;
	logic [3:0] mmfs_bank;

	// bank numbers move with the mapping option
	assign basic_bank = rom_map_low ? bbc_mem_pkg::romsel_basic_low
		: bbc_mem_pkg::romsel_basic_high;
	assign mmfs_bank  = rom_map_low ? bbc_mem_pkg::romsel_mmfs_low
		: bbc_mem_pkg::romsel_mmfs_high;

	always_comb begin
		case (cpu.region)
			bbc_mem_pkg::region_paged: begin
				if (cpu.romsel == basic_bank)
					cpu.rdata = basic_rdata;
				else if (cpu.romsel == mmfs_bank)
					cpu.rdata = mmfs_rdata;
				else if (cpu.romsel == bbc_mem_pkg::romsel_swram_a)
					cpu.rdata = ram_rdata; // extra sideways ram
				else
					cpu.rdata = 8'hff;     // empty socket
			end
			bbc_mem_pkg::region_mos: cpu.rdata = os_rdata;
			default:                 cpu.rdata = ram_rdata; // main and sideways ram
		endcase
	end

endmodule

// ==== src/bbc_mem_sys.sv ====
`timescale 1ns/1ps

module bbc_mem_sys (
	input  logic        clk_32m,
	input  logic        reset,
	input  logic        sdram_ready,
	input  logic        menu_reset,
	input  logic        core_button,
	input  logic        rom_map_low,
	input  logic        auto_boot,
	input  logic        mem_sync,
	input  logic [15:0] mem_adr,
	input  logic [3:0]  mem_romsel,
	input  logic        mem_we,
	input  logic [7:0]  mem_wdata,
	input  logic        loader_active,
	input  logic        loader_we,
	input  logic [24:0] loader_addr,
	input  logic [7:0]  loader_data,
	input  logic [7:0]  ram_rdata,
	input  logic [7:0]  os_rdata,
	input  logic [7:0]  basic_rdata,
	input  logic [7:0]  mmfs_rdata,
	output logic [7:0]  mem_rdata,
	output logic [24:0] sdram_adr,
	output logic        sdram_we,
	output logic [7:0]  sdram_wdata,
	output logic        core_reset,
	output logic        autoboot_shift
);

	cpu_bus_if cpu_bus ();
	loader_if  loader ();

	assign cpu_bus.adr    = mem_adr;
	assign cpu_bus.romsel = mem_romsel;
	assign cpu_bus.we     = mem_we;
	assign cpu_bus.wdata  = mem_wdata;
	assign mem_rdata      = cpu_bus.rdata;

	assign loader.active  = loader_active;
	assign loader.we      = loader_we;
	assign loader.addr    = loader_addr;
	assign loader.data    = loader_data;

	reset_ctrl u_reset_ctrl (
		.clk_32m        (clk_32m),
		.reset          (reset),
		.sdram_ready    (sdram_ready),
		.menu_reset     (menu_reset),
		.core_button    (core_button),
		.loader_active  (loader_active),
		.rom_map_low    (rom_map_low),
		.auto_boot      (auto_boot),
		.mem_sync       (mem_sync),
		.core_reset     (core_reset),
		.autoboot_shift (autoboot_shift)
	);

	sdram_port_mux u_sdram_port_mux (
		.cpu         (cpu_bus.mapper),
		.ldr         (loader.mux),
		.sdram_adr   (sdram_adr),
		.sdram_we    (sdram_we),
		.sdram_wdata (sdram_wdata)
	);

	cpu_read_mux u_cpu_read_mux (
		.cpu         (cpu_bus.reader),
		.rom_map_low (rom_map_low),
		.ram_rdata   (ram_rdata),
		.os_rdata    (os_rdata),
		.basic_rdata (basic_rdata),
		.mmfs_rdata  (mmfs_rdata)
	);

endmodule

// ==== tb/bbc_mem_sys_assertions.sv ====
`timescale 1ns/1ps

module bbc_mem_sys_assertions (
	input logic        clk_32m, reset, sdram_ready, menu_reset, core_button,
	input logic        rom_map_low, auto_boot, mem_sync, mem_we, loader_active, loader_we,
	input logic [15:0] mem_adr,
	input logic [3:0]  mem_romsel,
	input logic [7:0]  mem_wdata, loader_data, ram_rdata, os_rdata, basic_rdata, mmfs_rdata,
	input logic [24:0] loader_addr, sdram_adr,
	input logic [7:0]  mem_rdata, sdram_wdata,
	input logic        sdram_we, core_reset, autoboot_shift
);

	int          fail_count = 0;
	logic        prev_map;
	logic [12:0] map_age;   // cycles since the last mapping change
	logic        model_hold;
	logic        sources;
	logic        sources_q;
	logic        core_q;
	logic [24:0] run_cnt;   // cycles since core reset released
	logic [24:0] exp_adr;
	logic        exp_we;
	logic [7:0]  exp_wdata;
	logic [7:0]  exp_rdata;

	task automatic log_failure(input string msg);
		$error("%s", msg);
		fail_count++;
	endtask

	always_ff @(posedge clk_32m) begin
		prev_map  <= rom_map_low;
		sources_q <= sources;
		core_q    <= core_reset;
		if (reset)
			map_age <= '0;
		else if (prev_map != rom_map_low)
			map_age <= 13'd1;
		else if (map_age != '0 && map_age != '1)
			map_age <= map_age + 1'b1;
		if (reset || core_reset)
			run_cnt <= '0;
		else if (run_cnt != '1)
			run_cnt <= run_cnt + 1'b1;
	end

	assign model_hold = (map_age != '0) && (map_age <= 13'(bbc_mem_pkg::remap_hold_cycles));
	assign sources = reset || !sdram_ready || menu_reset || core_button || loader_active ||
		model_hold;

	always_comb begin
		exp_adr   = !mem_adr[15] ? {9'd0, mem_adr} : {7'h01, mem_romsel, mem_adr[13:0]};
		exp_we    = mem_we && (!mem_adr[15] || (!mem_adr[14] && mem_romsel[3:2] == 2'b01));
		exp_wdata = mem_wdata;
		if (loader_active) begin
			exp_adr   = loader_addr;
			exp_we    = loader_we;
			exp_wdata = loader_data;
		end
	end

	always_comb begin
		if (!mem_adr[15] || (!mem_adr[14] && mem_romsel[3:2] == 2'b01))
			exp_rdata = ram_rdata;
		else if (mem_adr[14])
			exp_rdata = os_rdata;
		else if (mem_romsel == (rom_map_low ? 4'h0 : 4'he))
			exp_rdata = basic_rdata;
		else if (mem_romsel == (rom_map_low ? 4'h2 : 4'hc))
			exp_rdata = mmfs_rdata;
		else if (mem_romsel == 4'ha)
			exp_rdata = ram_rdata;
		else
			exp_rdata = 8'hff; // unmapped bank
	end

	a_adr: assert property (@(posedge clk_32m) sdram_adr == exp_adr)
		else log_failure($sformatf("ERROR sdram_adr %h expected %h", sdram_adr, exp_adr));
	a_we: assert property (@(posedge clk_32m) sdram_we == exp_we)
		else log_failure($sformatf("ERROR sdram_we %h expected %h", sdram_we, exp_we));
	a_wdata: assert property (@(posedge clk_32m) sdram_wdata == exp_wdata)
		else log_failure($sformatf("ERROR sdram_wdata %h expected %h", sdram_wdata, exp_wdata));
	a_rdata: assert property (@(posedge clk_32m) mem_rdata == exp_rdata)
		else log_failure($sformatf("ERROR mem_rdata %h expected %h", mem_rdata, exp_rdata));

	a_board_reset: assert property (@(posedge clk_32m) reset |=> core_reset)
		else log_failure($sformatf("ERROR core_reset %h expected %h", core_reset, 1'b1));
	a_sync_update: assert property (@(posedge clk_32m) disable iff (reset)
		mem_sync |=> core_reset == sources_q)
		else log_failure($sformatf("ERROR core_reset %h expected %h", core_reset, sources_q));
	a_sync_keep: assert property (@(posedge clk_32m) disable iff (reset)
		!mem_sync |=> core_reset == core_q)
		else log_failure($sformatf("ERROR core_reset %h expected %h", core_reset, core_q));
	a_remap_hold: assert property (@(posedge clk_32m) disable iff (reset)
		model_hold && core_reset |=> core_reset)
		else log_failure($sformatf("ERROR core_reset %h expected %h", core_reset, 1'b1));

	// shift state lags core_reset by one clock
	a_shift_in_reset: assert property (@(posedge clk_32m) core_reset && core_q |-> !autoboot_shift)
		else log_failure($sformatf("ERROR autoboot_shift %h expected %h", autoboot_shift, 1'b0));
	a_shift_disabled: assert property (@(posedge clk_32m) !auto_boot |-> !autoboot_shift)
		else log_failure($sformatf("ERROR autoboot_shift %h expected %h", autoboot_shift, 1'b0));
	a_shift_window: assert property (@(posedge clk_32m) disable iff (reset)
		auto_boot && !core_reset && run_cnt != '0 && run_cnt < bbc_mem_pkg::autoboot_cycles
		|-> autoboot_shift)
		else log_failure($sformatf("ERROR autoboot_shift %h expected %h", autoboot_shift, 1'b1));

endmodule

bind bbc_mem_sys bbc_mem_sys_assertions u_bbc_mem_sys_assertions (.*);

// ==== tb/bbc_mem_sys_tb.sv ====
`timescale 1ns/1ps

module bbc_mem_sys_tb;

	logic        clk_32m;
	logic        reset;
	logic        sdram_ready;
	logic        menu_reset;
	logic        core_button;
	logic        rom_map_low;
	logic        auto_boot;
	logic        mem_sync = 1'b0;
	logic [1:0]  sync_phase = 2'd0;
	logic [15:0] mem_adr;
	logic [3:0]  mem_romsel;
	logic        mem_we;
	logic [7:0]  mem_wdata;
	logic        loader_active;
	logic        loader_we;
	logic [24:0] loader_addr;
	logic [7:0]  loader_data;
	logic [7:0]  ram_rdata;
	logic [7:0]  os_rdata;
	logic [7:0]  basic_rdata;
	logic [7:0]  mmfs_rdata;
	logic [7:0]  mem_rdata;
	logic [24:0] sdram_adr;
	logic        sdram_we;
	logic [7:0]  sdram_wdata;
	logic        core_reset;
	logic        autoboot_shift;
	int          timeouts;
	int          failures;

	bbc_mem_sys u_bbc_mem_sys (.*);

	initial begin
		clk_32m = 1'b0;
		forever #50 clk_32m = ~clk_32m;
	end

	// memory cycle strobe on one clock in four
	always @(posedge clk_32m) begin
		sync_phase <= sync_phase + 1'b1;
		mem_sync   <= (sync_phase == 2'd3);
	end

	// fresh random cpu bus, loader bus and rom bytes every clock
	task automatic drive_traffic(input int cycles);
		repeat (cycles) begin
			@(posedge clk_32m);
			mem_adr     <= 16'($urandom);
			mem_romsel  <= 4'($urandom);
			mem_we      <= 1'($urandom);
			mem_wdata   <= 8'($urandom);
			loader_we   <= 1'($urandom);
			loader_addr <= 25'($urandom);
			loader_data <= 8'($urandom);
			ram_rdata   <= 8'($urandom);
			os_rdata    <= 8'($urandom);
			basic_rdata <= 8'($urandom);
			mmfs_rdata  <= 8'($urandom);
		end
	endtask

	// returns just after a rising edge so the caller can drive on it
	task automatic wait_reset_level(input logic level, input int limit);
		int n;
		n = 0;
		@(negedge clk_32m);
		while (core_reset !== level && n < limit) begin
			drive_traffic(1);
			@(negedge clk_32m);
			n++;
		end
		if (core_reset !== level) begin
			timeouts++;
			$display("timeout: core_reset did not go to %0b within %0d cycles", level, limit);
		end
		@(posedge clk_32m);
	endtask

	task automatic pulse_source(input int which);
		case (which)
			0: reset <= 1'b1;
			1: sdram_ready <= 1'b0;
			2: menu_reset <= 1'b1;
			3: core_button <= 1'b1;
			default: loader_active <= 1'b1; // loader also owns the sdram port
		endcase
		drive_traffic(9);
		reset         <= 1'b0;
		sdram_ready   <= 1'b1;
		menu_reset    <= 1'b0;
		core_button   <= 1'b0;
		loader_active <= 1'b0;
		wait_reset_level(1'b0, 32);
	endtask

	initial begin
		void'($urandom(32'hbfec01fc));
		timeouts      = 0;
		reset         = 1'b1;
		sdram_ready   = 1'b0;
		menu_reset    = 1'b0;
		core_button   = 1'b0;
		rom_map_low   = 1'b0;
		auto_boot     = 1'b1;
		mem_adr       = '0;
		mem_romsel    = '0;
		mem_we        = 1'b0;
		mem_wdata     = '0;
		loader_active = 1'b0;
		loader_we     = 1'b0;
		loader_addr   = '0;
		loader_data   = '0;
		ram_rdata     = '0;
		os_rdata      = '0;
		basic_rdata   = '0;
		mmfs_rdata    = '0;
		repeat (3) @(posedge clk_32m);
		reset       <= 1'b0;
		sdram_ready <= 1'b1;
		wait_reset_level(1'b0, 64);
		drive_traffic(1000); // shift still pressed here

		for (int src = 0; src < 5; src++)
			pulse_source(src);

		auto_boot <= 1'b0;
		pulse_source(2);
		drive_traffic(50);
		auto_boot <= 1'b1;

		rom_map_low <= 1'b1; // low mapping starts the remap hold
		wait_reset_level(1'b1, 16);
		wait_reset_level(1'b0, 4095 + 32);
		drive_traffic(300);
		@(negedge clk_32m);

		failures = u_bbc_mem_sys.u_bbc_mem_sys_assertions.fail_count;
		$display("assertion failures: %0d, timeouts: %0d", failures, timeouts);
		if (failures == 0 && timeouts == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== bbc_mem_sys.f ====
src/bbc_mem_pkg.sv
src/cpu_bus_if.sv
src/loader_if.sv
src/reset_ctrl.sv
src/sdram_port_mux.sv
src/cpu_read_mux.sv
src/bbc_mem_sys.sv
tb/bbc_mem_sys_assertions.sv
tb/bbc_mem_sys_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the bbc_mem_sys testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module bbc_mem_sys_tb \
	-f bbc_mem_sys.f -o bbc_mem_sys_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

# keep running past assertion errors so the testbench prints its summary
./obj_dir/bbc_mem_sys_sim +verilator+error+limit+100000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation failed" sim.log; then
	exit 1
fi
exit 0
